// File: common/hbus_pkg.sv
/* Shared widths, latency counts, types and state encoding for the HyperBus controller.
   Every RTL file refers to these by scoped name. */

package hbus_pkg;

    // Bus and host widths
    localparam int DQ_W   = 8;
    localparam int WORD_W = 2 * DQ_W;
    localparam int MASK_W = WORD_W / 8;
    localparam int ADDR_W = 32;

    // Initial latency in clk cycles, doubled on request of the device
    localparam int TACC_COUNT  = 6;
    // Cycles the device reset stays low after rst
    localparam int RESET_COUNT = 5;
    // Wide enough for the doubled latency
    localparam int CNT_W       = $clog2(2 * TACC_COUNT + 1);

    typedef logic [ADDR_W-1:0] hbus_addr_t;
    typedef logic [WORD_W-1:0] hbus_word_t;
    typedef logic [MASK_W-1:0] hbus_mask_t;
    typedef logic [47:0]       hbus_ca_t;

    // Host request, levels held for the whole transfer
    typedef struct packed {
        hbus_addr_t addr;
        hbus_word_t wdata;
        hbus_mask_t mask;
        logic       reg_space;
        logic       wrq;
        logic       rrq;
    } hbus_req_t;

    // Drive side of the DDR lanes, one clk cycle worth of beats
    typedef struct packed {
        hbus_word_t dq;
        logic       dq_oe;
        logic [1:0] rwds;
        logic       rwds_oe;
    } hbus_pad_t;

    // One-hot controller states
    typedef enum logic [6:0] {
        RESET   = 7'b0000001,
        IDLE    = 7'b0000010,
        CLKEN   = 7'b0000100,
        COMMAND = 7'b0001000,
        LATENCY = 7'b0010000,
        READ    = 7'b0100000,
        WRITE   = 7'b1000000
    } hbus_state_e;

endpackage

// File: hw/hbus_ioddr.sv
/* Behavioral DDR lane: one 2N-bit word per clk cycle out as two N-bit beats, and back.
   Used at DQ width for data and at width 1 for RWDS. */

module hbus_ioddr #(
    parameter int LANE_W = hbus_pkg::DQ_W
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [2*LANE_W-1:0] dat_i,
    input  logic                oe_i,
    input  logic [LANE_W-1:0]   pad_i,
    output logic [2*LANE_W-1:0] dat_o,
    output logic [LANE_W-1:0]   pad_o,
    output logic                pad_oe_o
);

    logic [2*LANE_W-1:0] out_q;
    logic                oe_q;
    logic [LANE_W-1:0]   rise_q;
    logic [LANE_W-1:0]   fall_q;

    // Output register
    always_ff @(posedge clk) begin
        out_q <= dat_i;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            oe_q <= 1'b0;
        end else begin
            oe_q <= oe_i;
        end
    end

    // Upper beat while clk is high, lower beat while low
    assign pad_o    = clk ? out_q[2*LANE_W-1:LANE_W] : out_q[LANE_W-1:0];
    assign pad_oe_o = oe_q;

    // Capture on both edges
    always_ff @(posedge clk) begin
        rise_q <= pad_i;
    end

    always_ff @(negedge clk) begin
        fall_q <= pad_i;
    end

    // Pair from the previous cycle, rising beat on top
    always_ff @(posedge clk) begin
        dat_o <= {rise_q, fall_q};
    end

endmodule

// File: hyperbus/hbus_clk_gate.sv
/* Bus clock gate: brings the clock enable into clk90 and gates clk90 onto the pin.
   The resulting bus clock sits centered on the DDR data driven from clk. */

module hbus_clk_gate (
    input  logic clk90,
    input  logic rst,
    input  logic clk_en_i,
    output logic hbus_clk_o
);

    logic en_meta_q;
    logic en_q;

    // First stage on the rising edge of clk90
    always_ff @(posedge clk90 or posedge rst) begin
        if (rst) begin
            en_meta_q <= 1'b0;
        end else begin
            en_meta_q <= clk_en_i;
        end
    end

    // Second stage on the falling edge
    // Enable only moves while clk90 is low, so no runt pulses on the pin
    always_ff @(negedge clk90 or posedge rst) begin
        if (rst) begin
            en_q <= 1'b0;
        end else begin
            en_q <= en_meta_q;
        end
    end

    assign hbus_clk_o = clk90 & en_q;

endmodule

// File: hyperbus/hbus_ctrl.sv
/* HyperBus transaction FSM: device reset, command/address, latency, then word streaming.
   Drives the DDR lanes through hbus_pad_t and reads back the captured beat pairs. */

module hbus_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  hbus_pkg::hbus_req_t  req_i,
    input  hbus_pkg::hbus_word_t dq_rd_i,
    input  logic [1:0]           rwds_rd_i,
    output hbus_pkg::hbus_pad_t  pad_o,
    output logic                 clk_en_o,
    output logic                 csn_o,
    output logic                 rstn_o,
    output hbus_pkg::hbus_word_t rdata_o,
    output logic                 ready_o,
    output logic                 valid_o
);

    hbus_pkg::hbus_state_e      state_q;
    hbus_pkg::hbus_ca_t         ca_q;
    logic [hbus_pkg::CNT_W-1:0] count_q;
    logic                       cs_q;
    logic                       clk_en_q;
    logic                       rstn_q;
    logic                       dq_oe_q;
    logic                       rwds_oe_q;

    assign csn_o    = ~cs_q;
    assign clk_en_o = clk_en_q;
    assign rstn_o   = rstn_q;

    // Write words go straight from the host port, otherwise the top CA word
    assign pad_o.dq      = (state_q == hbus_pkg::WRITE) ? req_i.wdata : ca_q[47:32];
    assign pad_o.dq_oe   = dq_oe_q;
    // RWDS carries the mask in a write and sits low otherwise
    assign pad_o.rwds    = (state_q == hbus_pkg::WRITE) ? req_i.mask : 2'b00;
    assign pad_o.rwds_oe = rwds_oe_q;

    // Word taken on this edge
    assign ready_o = (state_q == hbus_pkg::WRITE) && req_i.wrq;

    // A read strobe shows up as high then low within one clk cycle
    assign rdata_o = dq_rd_i;
    assign valid_o = (state_q == hbus_pkg::READ) && req_i.rrq && (rwds_rd_i == 2'b10);

    // CA register
    // Reloaded every idle cycle, shifted one word per cycle once the clock is on
    always_ff @(posedge clk) begin
        if (state_q == hbus_pkg::IDLE) begin
            // R/W#, address space, linear burst, row and upper column, lower column
            ca_q <= {req_i.rrq, req_i.reg_space, 1'b1,
                     req_i.addr[hbus_pkg::ADDR_W-1:3], 13'd0, req_i.addr[2:0]};
        end else if (state_q == hbus_pkg::CLKEN || state_q == hbus_pkg::COMMAND) begin
            ca_q <= ca_q << hbus_pkg::WORD_W;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= hbus_pkg::RESET;
            count_q   <= hbus_pkg::CNT_W'(hbus_pkg::RESET_COUNT);
            cs_q      <= 1'b0;
            clk_en_q  <= 1'b0;
            rstn_q    <= 1'b0;
            dq_oe_q   <= 1'b0;
            rwds_oe_q <= 1'b0;
        end else begin
            case (state_q)
                hbus_pkg::RESET: begin
                    // Device reset held low until the count runs out
                    count_q <= count_q - 1'b1;
                    if (count_q == '0) begin
                        count_q <= '0;
                        rstn_q  <= 1'b1;
                        state_q <= hbus_pkg::IDLE;
                    end
                end

                hbus_pkg::IDLE: begin
                    if (count_q != '0) begin
                        // Recovery with csn high
                        count_q <= count_q - 1'b1;
                    end else if (req_i.rrq || req_i.wrq) begin
                        // Three CA words plus one cycle for the RWDS capture
                        count_q  <= hbus_pkg::CNT_W'(3);
                        cs_q     <= 1'b1;
                        clk_en_q <= 1'b1;
                        dq_oe_q  <= 1'b1;
                        state_q  <= hbus_pkg::CLKEN;
                    end
                end

                hbus_pkg::CLKEN: begin
                    // Gate opens in clk90 while the first CA word leaves the DDR register
                    state_q <= hbus_pkg::COMMAND;
                end

                hbus_pkg::COMMAND: begin
                    count_q <= count_q - 1'b1;
                    // Last CA word already handed to the lane, release DQ after it
                    if (count_q == hbus_pkg::CNT_W'(2)) begin
                        dq_oe_q <= 1'b0;
                    end
                    if (count_q == '0) begin
                        // RWDS high during the command asks for doubled latency
                        if (rwds_rd_i == 2'b11) begin
                            count_q <= hbus_pkg::CNT_W'(2 * hbus_pkg::TACC_COUNT - 2);
                        end else begin
                            count_q <= hbus_pkg::CNT_W'(hbus_pkg::TACC_COUNT - 2);
                        end
                        state_q <= hbus_pkg::LATENCY;
                    end
                end

                hbus_pkg::LATENCY: begin
                    count_q <= count_q - 1'b1;
                    if (count_q == '0) begin
                        count_q <= '0;
                        // Read wins, same priority as the R/W# bit of the CA
                        if (req_i.rrq) begin
                            state_q <= hbus_pkg::READ;
                        end else if (req_i.wrq) begin
                            // Lanes turn on together with the first data word
                            dq_oe_q   <= 1'b1;
                            rwds_oe_q <= 1'b1;
                            state_q   <= hbus_pkg::WRITE;
                        end else begin
                            // Request gone during latency
                            count_q  <= hbus_pkg::CNT_W'(3);
                            cs_q     <= 1'b0;
                            clk_en_q <= 1'b0;
                            state_q  <= hbus_pkg::IDLE;
                        end
                    end
                end

                hbus_pkg::READ: begin
                    // Device paces the words, nothing to do until rrq drops
                    if (!req_i.rrq) begin
                        count_q  <= hbus_pkg::CNT_W'(3);
                        cs_q     <= 1'b0;
                        clk_en_q <= 1'b0;
                        state_q  <= hbus_pkg::IDLE;
                    end
                end

                hbus_pkg::WRITE: begin
                    if (!req_i.wrq) begin
                        count_q   <= hbus_pkg::CNT_W'(3);
                        cs_q      <= 1'b0;
                        clk_en_q  <= 1'b0;
                        dq_oe_q   <= 1'b0;
                        rwds_oe_q <= 1'b0;
                        state_q   <= hbus_pkg::IDLE;
                    end
                end

                default: begin
                    // Illegal encoding, start over with a device reset
                    count_q   <= hbus_pkg::CNT_W'(hbus_pkg::RESET_COUNT);
                    cs_q      <= 1'b0;
                    clk_en_q  <= 1'b0;
                    rstn_q    <= 1'b0;
                    dq_oe_q   <= 1'b0;
                    rwds_oe_q <= 1'b0;
                    state_q   <= hbus_pkg::RESET;
                end
            endcase
        end
    end

endmodule

// File: hw/hbus_top.sv
/* HyperBus controller top: host word port on one side, split HyperRAM pad pins on the other.
   A board wrapper adds the tristate buffers for DQ and RWDS. */

module hbus_top (
    input  logic                        clk_i,
    input  logic                        clk90_i,
    input  logic                        rst_i,
    input  hbus_pkg::hbus_req_t         req_i,
    input  logic [hbus_pkg::DQ_W-1:0]   hbus_dq_i,
    input  logic                        hbus_rwds_i,
    output hbus_pkg::hbus_word_t        rdata_o,
    output logic                        ready_o,
    output logic                        valid_o,
    output logic                        hbus_clk_o,
    output logic                        hbus_csn_o,
    output logic                        hbus_rstn_o,
    output logic [hbus_pkg::DQ_W-1:0]   hbus_dq_o,
    output logic                        hbus_dq_oe_o,
    output logic                        hbus_rwds_o,
    output logic                        hbus_rwds_oe_o
);

    hbus_pkg::hbus_pad_t  pad;
    hbus_pkg::hbus_word_t dq_rd;
    logic [1:0]           rwds_rd;
    logic                 clk_en;

    hbus_ctrl u_ctrl (
        .clk       (clk_i),
        .rst       (rst_i),
        .req_i     (req_i),
        .dq_rd_i   (dq_rd),
        .rwds_rd_i (rwds_rd),
        .pad_o     (pad),
        .clk_en_o  (clk_en),
        .csn_o     (hbus_csn_o),
        .rstn_o    (hbus_rstn_o),
        .rdata_o   (rdata_o),
        .ready_o   (ready_o),
        .valid_o   (valid_o)
    );

    hbus_clk_gate u_clk_gate (
        .clk90      (clk90_i),
        .rst        (rst_i),
        .clk_en_i   (clk_en),
        .hbus_clk_o (hbus_clk_o)
    );

    // Data lane
    hbus_ioddr #(
        .LANE_W (hbus_pkg::DQ_W)
    ) u_ddr_dq (
        .clk      (clk_i),
        .rst      (rst_i),
        .dat_i    (pad.dq),
        .oe_i     (pad.dq_oe),
        .pad_i    (hbus_dq_i),
        .dat_o    (dq_rd),
        .pad_o    (hbus_dq_o),
        .pad_oe_o (hbus_dq_oe_o)
    );

    // Strobe and mask lane
    hbus_ioddr #(
        .LANE_W (1)
    ) u_ddr_rwds (
        .clk      (clk_i),
        .rst      (rst_i),
        .dat_i    (pad.rwds),
        .oe_i     (pad.rwds_oe),
        .pad_i    (hbus_rwds_i),
        .dat_o    (rwds_rd),
        .pad_o    (hbus_rwds_o),
        .pad_oe_o (hbus_rwds_oe_o)
    );

endmodule

// File: tests/hbus_ram_model.sv
/* Behavioral HyperRAM for the testbench: resolves the split pad pins, decodes the CA,
   holds a small word memory and an ID register, and can ask for doubled latency. */

module hbus_ram_model #(
    parameter logic [15:0] ID_REG = 16'h0c81
) (
    input  logic               ck_i,
    input  logic               csn_i,
    input  logic               rstn_i,
    input  logic [7:0]         dut_dq_i,
    input  logic               dut_dq_oe_i,
    input  logic               dut_rwds_i,
    input  logic               dut_rwds_oe_i,
    input  logic               double_i,
    output logic [7:0]         dq_o,
    output logic               rwds_o,
    output hbus_pkg::hbus_ca_t ca_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0]        mem [256];
    hbus_pkg::hbus_ca_t ca_sr;
    int                 edge_cnt;
    int                 first_edge;
    int                 d;
    logic [7:0]         word_addr;
    logic               is_read;
    logic               is_reg;
    logic               rd_phase;
    logic [7:0]         rd_dq;
    logic               rd_rwds;
    logic [15:0]        rd_word;

    // Bus as seen on the board, the DUT wins while its enable is on
    assign dq_o   = dut_dq_oe_i ? dut_dq_i : rd_dq;
    // RWDS high through command and latency when doubled latency is wanted
    assign rwds_o = dut_rwds_oe_i ? dut_rwds_i :
                    (rd_phase ? rd_rwds : (~csn_i & double_i));

    initial begin
        // Pattern built from every address bit
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i), ~8'(i)};
        end
        rd_phase   = 1'b0;
        rd_dq      = 8'h00;
        rd_rwds    = 1'b0;
        edge_cnt   = 0;
        first_edge = 0;
        ca_o       = '0;
    end

    // Both bus clock edges count; csn high ends the transaction
    always @(posedge ck_i or negedge ck_i or posedge csn_i) begin
        if (csn_i || !rstn_i) begin
            edge_cnt = 0;
            rd_phase = 1'b0;
            rd_rwds  = 1'b0;
            rd_dq    = 8'h00;
        end else begin
            if (edge_cnt < 6) begin
                // Six CA bytes, most significant first
                ca_sr = {ca_sr[39:0], dq_o};
                if (edge_cnt == 5) begin
                    ca_o      = ca_sr;
                    is_read   = ca_sr[47];
                    is_reg    = ca_sr[46];
                    word_addr = {ca_sr[20:16], ca_sr[2:0]};
                    // Data starts after the four command cycles plus the latency
                    first_edge = 2 * (4 + (double_i ? 2 * hbus_pkg::TACC_COUNT
                                                    : hbus_pkg::TACC_COUNT));
                end
            end else if (edge_cnt >= first_edge) begin
                d = edge_cnt - first_edge;
                if (!is_read) begin
                    // Upper byte on the rising edge, RWDS high masks the byte
                    if (!is_reg && !rwds_o) begin
                        if (d % 2 == 0) begin
                            mem[word_addr][15:8] = dq_o;
                        end else begin
                            mem[word_addr][7:0] = dq_o;
                        end
                    end
                    if (d % 2 == 1) begin
                        word_addr = word_addr + 8'd1;
                    end
                end else begin
                    rd_word = is_reg ? ID_REG : mem[word_addr];
                    // Output half a bus clock late so the pair lines up with clk capture
                    if (d % 2 == 1) begin
                        rd_phase = 1'b1;
                        rd_dq    = rd_word[15:8];
                        rd_rwds  = 1'b1;
                    end else if (d > 0) begin
                        rd_dq     = rd_word[7:0];
                        rd_rwds   = 1'b0;
                        word_addr = word_addr + 8'd1;
                    end
                end
            end
            edge_cnt = edge_cnt + 1;
        end
    end

endmodule

// File: tests/tb_hbus.sv
/* Testbench for hbus_top against the HyperRAM model.
   Runs directed tests for reset, CA decode, latency, byte mask and register reads. */

module tb_hbus;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TIMEOUT  = 200;
    localparam logic [15:0] ID_VALUE = 16'h0c81;

    logic                 clk;
    logic                 clk90;
    logic                 rst;
    hbus_pkg::hbus_req_t  req;
    hbus_pkg::hbus_word_t rdata;
    logic                 ready;
    logic                 valid;
    logic                 hbus_clk;
    logic                 hbus_csn;
    logic                 hbus_rstn;
    logic [7:0]           dut_dq;
    logic                 dut_dq_oe;
    logic                 dut_rwds;
    logic                 dut_rwds_oe;
    logic [7:0]           bus_dq;
    logic                 bus_rwds;
    logic                 double_lat;
    hbus_pkg::hbus_ca_t   model_ca;
    int                   checks;
    int                   errors;
    int                   timeouts;

    initial clk = 1'b0;
    always #4 clk = ~clk;
    // clk90 trails clk by a quarter period
    assign #2 clk90 = clk;

    hbus_top DUT (
        .clk_i          (clk),
        .clk90_i        (clk90),
        .rst_i          (rst),
        .req_i          (req),
        .hbus_dq_i      (bus_dq),
        .hbus_rwds_i    (bus_rwds),
        .rdata_o        (rdata),
        .ready_o        (ready),
        .valid_o        (valid),
        .hbus_clk_o     (hbus_clk),
        .hbus_csn_o     (hbus_csn),
        .hbus_rstn_o    (hbus_rstn),
        .hbus_dq_o      (dut_dq),
        .hbus_dq_oe_o   (dut_dq_oe),
        .hbus_rwds_o    (dut_rwds),
        .hbus_rwds_oe_o (dut_rwds_oe)
    );

    hbus_ram_model #(
        .ID_REG (ID_VALUE)
    ) u_ram (
        .ck_i          (hbus_clk),
        .csn_i         (hbus_csn),
        .rstn_i        (hbus_rstn),
        .dut_dq_i      (dut_dq),
        .dut_dq_oe_i   (dut_dq_oe),
        .dut_rwds_i    (dut_rwds),
        .dut_rwds_oe_i (dut_rwds_oe),
        .double_i      (double_lat),
        .dq_o          (bus_dq),
        .rwds_o        (bus_rwds),
        .ca_o          (model_ca)
    );

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // Bus back in idle with csn high
    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!hbus_csn && n < TIMEOUT);
        if (!hbus_csn) begin
            timeouts++;
            $display("Timeout: chip select never went back high");
        end
    endtask

    // Single-word write, word taken on the edge after ready
    task automatic write_word(input hbus_pkg::hbus_addr_t addr, input hbus_pkg::hbus_word_t data,
                              input hbus_pkg::hbus_mask_t mask, input logic reg_space);
        int n;
        @(posedge clk);
        req.addr      <= addr;
        req.wdata     <= data;
        req.mask      <= mask;
        req.reg_space <= reg_space;
        req.wrq       <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ready && n < TIMEOUT);
        if (!ready) begin
            timeouts++;
            $display("Timeout: write at 0x%0h was never accepted", addr);
        end
        @(posedge clk);
        req.wrq <= 1'b0;
        wait_idle();
    endtask

    task automatic read_word(input hbus_pkg::hbus_addr_t addr, input logic reg_space,
                             output hbus_pkg::hbus_word_t data);
        int n;
        @(posedge clk);
        req.addr      <= addr;
        req.reg_space <= reg_space;
        req.rrq       <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!valid && n < TIMEOUT);
        if (!valid) begin
            timeouts++;
            $display("Timeout: read at 0x%0h returned no valid word", addr);
        end
        data = rdata;
        @(posedge clk);
        req.rrq <= 1'b0;
        wait_idle();
    endtask

    task automatic reset_release();
        int n;
        n = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // Device reset low for RESET_COUNT+1 cycles, bus quiet meanwhile
        do begin
            @(negedge clk);
            check_value("hbus_csn_o", 64'(hbus_csn), 64'h1);
            // clk90 is still high here, so an ungated clock would show
            check_value("hbus_clk_o", 64'(hbus_clk), 64'h0);
            check_value("ready_o", 64'(ready), 64'h0);
            check_value("valid_o", 64'(valid), 64'h0);
            check_value("hbus_dq_oe_o", 64'(dut_dq_oe), 64'h0);
            check_value("hbus_rwds_oe_o", 64'(dut_rwds_oe), 64'h0);
            if (!hbus_rstn) begin
                n++;
            end
        end while (!hbus_rstn && n < TIMEOUT);
        check_value("hbus_rstn_o low cycles", 64'(n), 64'(hbus_pkg::RESET_COUNT + 1));
    endtask

    task automatic command_decode();
        hbus_pkg::hbus_addr_t addr;
        logic                 reg_space;
        addr      = $urandom();
        reg_space = 1'($urandom());
        write_word(addr, 16'($urandom()), 2'b00, reg_space);
        check_value("ca r/w", 64'(model_ca[47]), 64'h0);
        check_value("ca space", 64'(model_ca[46]), 64'(reg_space));
        check_value("ca burst", 64'(model_ca[45]), 64'h1);
        check_value("ca upper addr", 64'(model_ca[44:16]), 64'(addr[31:3]));
        check_value("ca lower addr", 64'(model_ca[2:0]), 64'(addr[2:0]));
    endtask

    task automatic round_trip(input logic doubled);
        hbus_pkg::hbus_addr_t addrs [8];
        hbus_pkg::hbus_word_t words [8];
        hbus_pkg::hbus_word_t got;
        @(posedge clk);
        double_lat <= doubled;
        // Low three bits keep the eight addresses apart
        for (int i = 0; i < 8; i++) begin
            addrs[i]      = $urandom();
            addrs[i][2:0] = 3'(i);
            words[i]      = 16'($urandom());
            write_word(addrs[i], words[i], 2'b00, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            read_word(addrs[i], 1'b0, got);
            check_value("rdata_o", 64'(got), 64'(words[i]));
        end
    endtask

    task automatic byte_mask_merge();
        hbus_pkg::hbus_word_t got;
        @(posedge clk);
        double_lat <= 1'b0;
        write_word(32'h0000_0040, 16'h1234, 2'b00, 1'b0);
        // Mask bit 0 keeps the old low byte
        write_word(32'h0000_0040, 16'habcd, 2'b01, 1'b0);
        read_word(32'h0000_0040, 1'b0, got);
        check_value("rdata_o masked", 64'(got), 64'h0000_ab34);
    endtask

    task automatic id_register_read();
        hbus_pkg::hbus_word_t got;
        read_word(32'h0000_0000, 1'b1, got);
        check_value("rdata_o id", 64'(got), 64'(ID_VALUE));
    endtask

    initial begin
        void'($urandom(14));
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        rst        = 1'b1;
        req        = '0;
        double_lat = 1'b0;
        reset_release();
        command_decode();
        round_trip(1'b0);
        round_trip(1'b1);
        byte_mask_merge();
        id_register_read();
        $display("Finished: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: list.f
common/hbus_pkg.sv
hw/hbus_ioddr.sv
hyperbus/hbus_clk_gate.sv
hyperbus/hbus_ctrl.sv
hw/hbus_top.sv
tests/hbus_ram_model.sv
tests/tb_hbus.sv

// File: run.sh
#!/bin/sh
# Build and run the HyperBus testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_hbus -o tb_hbus
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_hbus)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
